// File: hw/sys_bus_config.svh
`ifndef SYS_BUS_CONFIG_SVH
`define SYS_BUS_CONFIG_SVH

// System I/O ports
`define SYS_PORT_BANK0      8'hF0
`define SYS_PORT_BANK1      8'hF1
`define SYS_PORT_BANK2      8'hF2
`define SYS_PORT_BANK3      8'hF3
`define SYS_PORT_KBBUF      8'hFA
`define SYS_PORT_SYSCTRL    8'hFB
`define SYS_PORT_CASSETTE   8'hFC
`define SYS_PORT_CPM        8'hFD   // Write only
`define SYS_PORT_PRINTER    8'hFE
`define SYS_PORT_KEYS       8'hFF

// Bank register values after reset
`define SYS_BANK0_RESET     8'hC0   // Read-only, overlay, page 0
`define SYS_BANK1_RESET     8'h21
`define SYS_BANK2_RESET     8'h22
`define SYS_BANK3_RESET     8'h13

// Physical page map, 16 KB pages
`define SYS_PAGE_ROM_LAST   6'd3
`define SYS_PAGE_CART_FIRST 6'd16   // Four cartridge pages
`define SYS_PAGE_VIDEO_FIRST 6'd20
`define SYS_PAGE_VIDEO_LAST 6'd21
`define SYS_PAGE_RAM_FIRST  6'd32   // RAM runs to the top page

`define SYS_KBBUF_DEPTH     16

`endif

// File: hw/z80_bus_pkg.sv
package z80_bus_pkg;

    // CPU address as seen on the expansion bus
    typedef logic [15:0] cpu_addr_t;

    // One byte on the data bus
    typedef logic [7:0] cpu_data_t;

    // I/O cycles only decode the low address byte
    typedef logic [7:0] io_port_t;

endpackage

// File: hw/mem_map_pkg.sv
package mem_map_pkg;

    // Physical 16 KB page, 64 of them
    typedef logic [5:0] page_t;

    // Page bits that leave the chip on the BA pins
    typedef logic [4:0] ext_page_t;

    // Bank picked by CPU address bits 15:14
    typedef logic [1:0] bank_sel_t;

    // Bit 7 read-only, bit 6 overlay, bits 5:0 page
    typedef logic [7:0] bank_reg_t;

    // Eight rows of eight keys, row i in bits 8*i+7:8*i
    typedef logic [63:0] key_matrix_t;

    // Which external device a memory cycle lands on
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_SYSRAM,     // Overlay window, always page 32
        MEM_RAM,
        MEM_CART
    } mem_sel_t;

endpackage

// File: hw/bus_sync.sv
module bus_sync (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_n,
    input  logic                   wr_n,
    input  z80_bus_pkg::cpu_data_t d_in,
    output logic                   bus_read,
    output logic                   bus_write,
    output z80_bus_pkg::cpu_data_t wr_data
);

    logic [2:0] rd_n_sync;   // Bit 0 is the newest sample
    logic [2:0] wr_n_sync;

    // Idle level is high, so reset can never look like a falling strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_sync <= '1;
            wr_n_sync <= '1;
        end else begin
            rd_n_sync <= {rd_n_sync[1:0], rd_n};
            wr_n_sync <= {wr_n_sync[1:0], wr_n};
        end
    end

    // One clock per strobe, on the high-to-low step of the late stages
    assign bus_read  = rd_n_sync[2:1] == 2'b10;
    assign bus_write = wr_n_sync[2:1] == 2'b10;

    // CPU holds data for the whole low phase of wr_n
    always_ff @(posedge clk) begin
        if (!wr_n)
            wr_data <= d_in;
    end

endmodule

// File: hw/mem_decode.sv
`include "sys_bus_config.svh"

module mem_decode (
    input  z80_bus_pkg::cpu_addr_t  a,
    input  logic                    mreq_n,
    input  logic                    wr_n,
    input  mem_map_pkg::bank_reg_t  bank0,
    input  mem_map_pkg::bank_reg_t  bank1,
    input  mem_map_pkg::bank_reg_t  bank2,
    input  mem_map_pkg::bank_reg_t  bank3,
    output mem_map_pkg::ext_page_t  ba,
    output logic                    ram_ce_n,
    output logic                    cart_ce_n,
    output logic                    ram_we_n
);
    import mem_map_pkg::*;

    bank_sel_t bank_sel;
    bank_reg_t bank;
    page_t     page;
    logic      read_only;
    logic      overlay;
    logic      sysram_hit;
    logic      allow;
    mem_sel_t  mem_sel;

    assign bank_sel = a[15:14];

    always_comb begin
        case (bank_sel)
            2'd0:    bank = bank0;
            2'd1:    bank = bank1;
            2'd2:    bank = bank2;
            default: bank = bank3;
        endcase
    end

    assign page      = bank[5:0];
    assign read_only = bank[7];
    assign overlay   = bank[6];

    // Top 2 KB of an overlay bank
    assign sysram_hit = overlay && a[13:11] == 3'b111;

    // Writes into a read-only bank go nowhere
    assign allow = wr_n || !read_only;

    // ROM and video pages fall outside both ranges below
    always_comb begin
        mem_sel = MEM_NONE;
        if (!mreq_n) begin
            if (sysram_hit)
                mem_sel = MEM_SYSRAM;   // Ignores the read-only bit
            else if (allow && page >= `SYS_PAGE_RAM_FIRST)
                mem_sel = MEM_RAM;
            else if (allow && page >= `SYS_PAGE_CART_FIRST &&
                     page <= `SYS_PAGE_CART_FIRST + 6'd3)
                mem_sel = MEM_CART;
        end
    end

    ////////////////////////////////
    // External pins
    ////////////////////////////////
    assign ba        = (mem_sel == MEM_SYSRAM) ? '0 : page[4:0];  // System RAM sits in page 32
    assign ram_ce_n  = !(mem_sel == MEM_SYSRAM || mem_sel == MEM_RAM);
    assign cart_ce_n = !(mem_sel == MEM_CART);
    assign ram_we_n  = wr_n || ram_ce_n;   // Read-only already filtered out above

endmodule

// File: hw/io_regs.sv
`include "sys_bus_config.svh"

module io_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  z80_bus_pkg::cpu_addr_t  a,
    input  logic                    iorq_n,
    input  logic                    rd_n,
    input  logic                    bus_read,
    input  logic                    bus_write,
    input  z80_bus_pkg::cpu_data_t  wr_data,
    input  z80_bus_pkg::cpu_data_t  kb_rd_data,
    input  z80_bus_pkg::cpu_data_t  key_rd_data,
    input  logic                    cassette_in,
    input  logic                    printer_in,
    output mem_map_pkg::bank_reg_t  bank0,
    output mem_map_pkg::bank_reg_t  bank1,
    output mem_map_pkg::bank_reg_t  bank2,
    output mem_map_pkg::bank_reg_t  bank3,
    output logic                    kb_sel,
    output logic                    kb_pop,
    output logic                    kb_clear,
    output z80_bus_pkg::cpu_data_t  d_out,
    output logic                    d_oe,
    output logic                    cassette_out,
    output logic                    printer_out
);
    import z80_bus_pkg::*;

    io_port_t   port;
    logic       io_cycle;
    logic       dis_regs;        // $FB bit 0
    logic [1:0] sysctrl_spare;   // $FB bits 2:1, storage only
    logic [2:0] cassette_sync;
    logic [2:0] printer_sync;
    logic       sel_bank0;
    logic       sel_bank1;
    logic       sel_bank2;
    logic       sel_bank3;
    logic       sel_kbbuf;
    logic       sel_sysctrl;
    logic       sel_cassette;
    logic       sel_cpm;
    logic       sel_printer;
    logic       sel_keys;
    logic       sel_internal;

    //////////////////////////////
    // Port decode
    //////////////////////////////
    assign port     = a[7:0];
    assign io_cycle = !iorq_n;

    // Bank registers vanish from I/O space while dis_regs is set
    assign sel_bank0    = io_cycle && !dis_regs && port == `SYS_PORT_BANK0;
    assign sel_bank1    = io_cycle && !dis_regs && port == `SYS_PORT_BANK1;
    assign sel_bank2    = io_cycle && !dis_regs && port == `SYS_PORT_BANK2;
    assign sel_bank3    = io_cycle && !dis_regs && port == `SYS_PORT_BANK3;
    assign sel_kbbuf    = io_cycle && port == `SYS_PORT_KBBUF;
    assign sel_sysctrl  = io_cycle && port == `SYS_PORT_SYSCTRL;
    assign sel_cassette = io_cycle && port == `SYS_PORT_CASSETTE;
    assign sel_cpm      = io_cycle && port == `SYS_PORT_CPM;
    assign sel_printer  = io_cycle && port == `SYS_PORT_PRINTER;
    assign sel_keys     = io_cycle && port == `SYS_PORT_KEYS;

    assign sel_internal = sel_bank0 | sel_bank1 | sel_bank2 | sel_bank3 |
                          sel_kbbuf | sel_sysctrl | sel_cassette | sel_cpm |
                          sel_printer | sel_keys;

    assign kb_sel   = sel_kbbuf;
    assign kb_pop   = sel_kbbuf && bus_read;    // Byte stays on the bus until here
    assign kb_clear = sel_kbbuf && bus_write;   // Any write flushes the buffer

    // Slow external inputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_sync <= '0;
            printer_sync  <= '0;
        end else begin
            cassette_sync <= {cassette_sync[1:0], cassette_in};
            printer_sync  <= {printer_sync[1:0], printer_in};
        end
    end

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank0         <= `SYS_BANK0_RESET;
            bank1         <= `SYS_BANK1_RESET;
            bank2         <= `SYS_BANK2_RESET;
            bank3         <= `SYS_BANK3_RESET;
            dis_regs      <= 1'b0;
            sysctrl_spare <= '0;
            cassette_out  <= 1'b0;
            printer_out   <= 1'b0;
        end else if (bus_write) begin
            if (sel_bank0)    bank0 <= wr_data;
            if (sel_bank1)    bank1 <= wr_data;
            if (sel_bank2)    bank2 <= wr_data;
            if (sel_bank3)    bank3 <= wr_data;
            if (sel_sysctrl)  {sysctrl_spare, dis_regs} <= wr_data[2:0];
            if (sel_cassette) cassette_out <= wr_data[0];
            if (sel_printer)  printer_out <= wr_data[0];
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////
    always_comb begin
        d_out = '0;
        if (sel_bank0)    d_out = bank0;
        if (sel_bank1)    d_out = bank1;
        if (sel_bank2)    d_out = bank2;
        if (sel_bank3)    d_out = bank3;
        if (sel_kbbuf)    d_out = kb_rd_data;
        if (sel_sysctrl)  d_out = {5'b0, sysctrl_spare, dis_regs};
        if (sel_cassette) d_out = {7'b0, !cassette_sync[2]};  // Input is inverted
        if (sel_printer)  d_out = {7'b0, printer_sync[2]};
        if (sel_keys)     d_out = key_rd_data;
        // $FD reads as 0
    end

    assign d_oe = !rd_n && sel_internal;

endmodule

// File: hw/keyboard.sv
`include "sys_bus_config.svh"

module keyboard #(
    parameter int depth = `SYS_KBBUF_DEPTH    // Power of two
) (
    input  logic                     clk,
    input  logic                     reset,
    input  z80_bus_pkg::cpu_addr_t   a,
    input  mem_map_pkg::key_matrix_t keys,
    input  z80_bus_pkg::cpu_data_t   kb_wr_data,
    input  logic                     kb_wr_en,
    input  logic                     kb_sel,
    input  logic                     kb_pop,
    input  logic                     kb_clear,
    output z80_bus_pkg::cpu_data_t   kb_rd_data,
    output z80_bus_pkg::cpu_data_t   key_rd_data
);
    import z80_bus_pkg::*;

    localparam int ptr_w = $clog2(depth);

    cpu_data_t        fifo_mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;     // One extra bit to tell full from empty
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    // Matrix read, active-low row select on address bits 15:8
    always_comb begin
        key_rd_data = 8'hFF;
        for (int i = 0; i < 8; i++) begin
            if (!a[8 + i])
                key_rd_data = key_rd_data & keys[i*8 +: 8];
        end
    end

    ////////////////////////////////
    // Keyboard buffer FIFO
    ////////////////////////////////
    assign empty = count == '0;
    assign full  = count == (ptr_w + 1)'(depth);
    assign push  = kb_wr_en && !full;   // No back-pressure, overflow is dropped
    assign pop   = kb_pop && !empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (kb_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= kb_wr_data;
    end

    assign kb_rd_data = (kb_sel && !empty) ? fifo_mem[rd_ptr] : '0;  // Oldest entry

endmodule

// File: hw/sys_bus_top.sv
`include "sys_bus_config.svh"

module sys_bus_top (
    input  logic                     clk,
    input  logic                     reset,

    // Z80 expansion bus
    input  logic                     rd_n,
    input  logic                     wr_n,
    input  logic                     mreq_n,
    input  logic                     iorq_n,
    input  z80_bus_pkg::cpu_addr_t   a,
    input  z80_bus_pkg::cpu_data_t   d_in,
    output z80_bus_pkg::cpu_data_t   d_out,
    output logic                     d_oe,

    // External memory
    output mem_map_pkg::ext_page_t   ba,
    output logic                     ram_ce_n,
    output logic                     cart_ce_n,
    output logic                     ram_we_n,

    // Keyboard
    input  mem_map_pkg::key_matrix_t keys,
    input  z80_bus_pkg::cpu_data_t   kb_wr_data,
    input  logic                     kb_wr_en,

    // Cassette and printer
    input  logic                     cassette_in,
    output logic                     cassette_out,
    input  logic                     printer_in,
    output logic                     printer_out
);
    import z80_bus_pkg::*;
    import mem_map_pkg::*;

    logic      bus_read;
    logic      bus_write;
    cpu_data_t wr_data;
    bank_reg_t bank0;
    bank_reg_t bank1;
    bank_reg_t bank2;
    bank_reg_t bank3;
    logic      kb_sel;
    logic      kb_pop;
    logic      kb_clear;
    cpu_data_t kb_rd_data;
    cpu_data_t key_rd_data;

    //////////////////////////////
    // Strobes and write data
    //////////////////////////////
    bus_sync u_bus_sync (
        .clk       (clk),
        .reset     (reset),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .d_in      (d_in),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .wr_data   (wr_data)
    );

    mem_decode u_mem_decode (
        .a         (a),
        .mreq_n    (mreq_n),
        .wr_n      (wr_n),
        .bank0     (bank0),
        .bank1     (bank1),
        .bank2     (bank2),
        .bank3     (bank3),
        .ba        (ba),
        .ram_ce_n  (ram_ce_n),
        .cart_ce_n (cart_ce_n),
        .ram_we_n  (ram_we_n)
    );

    //////////////////////////////
    // I/O space
    //////////////////////////////
    io_regs u_io_regs (
        .clk          (clk),
        .reset        (reset),
        .a            (a),
        .iorq_n       (iorq_n),
        .rd_n         (rd_n),
        .bus_read     (bus_read),
        .bus_write    (bus_write),
        .wr_data      (wr_data),
        .kb_rd_data   (kb_rd_data),
        .key_rd_data  (key_rd_data),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .bank0        (bank0),
        .bank1        (bank1),
        .bank2        (bank2),
        .bank3        (bank3),
        .kb_sel       (kb_sel),
        .kb_pop       (kb_pop),
        .kb_clear     (kb_clear),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    keyboard #(
        .depth (`SYS_KBBUF_DEPTH)
    ) u_keyboard (
        .clk         (clk),
        .reset       (reset),
        .a           (a),
        .keys        (keys),
        .kb_wr_data  (kb_wr_data),
        .kb_wr_en    (kb_wr_en),
        .kb_sel      (kb_sel),
        .kb_pop      (kb_pop),
        .kb_clear    (kb_clear),
        .kb_rd_data  (kb_rd_data),
        .key_rd_data (key_rd_data)
    );

endmodule

// File: tb/sys_bus_assertions.sv
module sys_bus_assertions (
    input logic clk,
    input logic reset,
    input logic rd_n,
    input logic d_oe,
    input logic ram_ce_n,
    input logic cart_ce_n,
    input logic ram_we_n
);

    int fail_count = 0;   // Read by the testbench top at the end

    // RAM and cartridge share the data pins
    assert property (@(posedge clk) disable iff (reset) !(!ram_ce_n && !cart_ce_n))
        else begin
            $error("RAM and cartridge enabled together");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset) d_oe |-> !rd_n)
        else begin
            $error("Data bus driven outside a read");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset) !ram_we_n |-> !ram_ce_n)
        else begin
            $error("RAM write enable without chip enable");
            fail_count++;
        end

endmodule

// File: tb/bus_checker.sv
module bus_checker (
    input  logic       clk,
    input  logic       check,
    input  int         test_num,
    input  int         op,
    input  logic [15:0] addr,
    input  logic [7:0] exp_dout,
    input  logic       exp_doe,
    input  logic [4:0] exp_ba,
    input  logic [2:0] exp_ce,      // ram_ce_n, cart_ce_n, ram_we_n
    input  logic [7:0] d_out,
    input  logic       d_oe,
    input  logic [4:0] ba,
    input  logic       ram_ce_n,
    input  logic       cart_ce_n,
    input  logic       ram_we_n,
    input  logic       cassette_out,
    input  logic       printer_out,
    output int         tests,
    output int         errors
);

    int bad;

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR test %0d %s got %h expected %h", test_num, name, got, exp);
            bad++;
        end
    endtask

    initial begin
        tests  = 0;
        errors = 0;
    end

    // Falling edge keeps sampling clear of the driving edge
    always @(negedge clk) begin
        if (check) begin
            bad = 0;
            if (op == 7) begin
                compare_value("pins", {6'b0, printer_out, cassette_out}, exp_dout);
            end else begin
                compare_value("d_oe", {7'b0, d_oe}, {7'b0, exp_doe});
                compare_value("ram_ce_n", {7'b0, ram_ce_n}, {7'b0, exp_ce[2]});
                compare_value("cart_ce_n", {7'b0, cart_ce_n}, {7'b0, exp_ce[1]});
                compare_value("ram_we_n", {7'b0, ram_we_n}, {7'b0, exp_ce[0]});
                if (op < 2)
                    compare_value("ba", {3'b0, ba}, {3'b0, exp_ba});
                if (op == 2)
                    compare_value("d_out", d_out, exp_dout);
            end
            tests++;
            errors += (bad != 0) ? 1 : 0;
            $display("test %0d op %0d addr %h: %s", test_num, op, addr,
                     (bad == 0) ? "ok" : "mismatch");
        end
    end

endmodule

// File: tb/tb_top.sv
module tb_top;

    localparam int reset_cycles = 16;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        rd_n, wr_n, mreq_n, iorq_n;
    logic [15:0] a;
    logic [7:0]  d_in, d_out, kb_wr_data;
    logic        d_oe, kb_wr_en, cassette_in, printer_in;
    logic [63:0] keys;
    logic [4:0]  ba;
    logic        ram_ce_n, cart_ce_n, ram_we_n, cassette_out, printer_out;

    // Expected values handed to the checker
    logic        check;
    int          test_num, cur_op, tests, errors;
    logic [7:0]  exp_dout;
    logic        exp_doe;
    logic [4:0]  exp_ba;
    logic [2:0]  exp_ce;

    int          ops[$], addrs[$], datas[$], douts[$], does[$], bas[$], ces[$];
    int          limit = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'hc526_7867;

    sys_bus_top DUT (.*);

    bind sys_bus_top sys_bus_assertions u_assertions (.*);

    bus_checker u_checker (.clk, .check, .test_num, .op(cur_op), .addr(a), .exp_dout,
        .exp_doe, .exp_ba, .exp_ce, .d_out, .d_oe, .ba, .ram_ce_n, .cart_ce_n,
        .ram_we_n, .cassette_out, .printer_out, .tests, .errors);

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);   // One step per bit
        end
        return b;
    endfunction

    task automatic bus_cycle(input int op, input int addr, input int data);
        @(posedge clk);
        a      <= addr[15:0];
        d_in   <= (op == 0) ? random_byte() : data[7:0];
        mreq_n <= op > 1;
        iorq_n <= op < 2;
        rd_n   <= op[0];
        wr_n   <= !op[0];
        repeat (2) @(posedge clk);
        check <= 1'b1;            // Before the pop edge
        @(posedge clk);
        check <= 1'b0;
        repeat (3) @(posedge clk);
        {rd_n, wr_n, mreq_n, iorq_n} <= 4'hF;
    endtask

    task automatic run_line(input int i);
        test_num = i;
        cur_op   = ops[i];
        exp_dout = douts[i][7:0];
        exp_doe  = does[i][0];
        exp_ba   = bas[i][4:0];
        exp_ce   = {ces[i][8], ces[i][4], ces[i][0]};
        case (ops[i])
            0, 1, 2, 3: bus_cycle(ops[i], addrs[i], datas[i]);
            4: begin
                @(posedge clk);
                keys[addrs[i][2:0]*8 +: 8] <= datas[i][7:0];
            end
            5: begin
                for (int k = 0; k < addrs[i]; k++) begin
                    @(posedge clk);
                    kb_wr_data <= 8'(datas[i] + k);
                    kb_wr_en   <= 1'b1;
                end
                @(posedge clk);
                kb_wr_en <= 1'b0;
            end
            6: begin
                @(posedge clk);
                cassette_in <= datas[i][0];
                printer_in  <= datas[i][1];
            end
            default: begin   // Output pin check
                @(posedge clk);
                check <= 1'b1;
                @(posedge clk);
                check <= 1'b0;
            end
        endcase
    endtask

    task automatic load_testdata(input int fd);
        string line;
        int    f[9];
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                        f[6]) == 7) begin
                ops.push_back(f[0]);
                addrs.push_back(f[1]);
                datas.push_back(f[2]);
                douts.push_back(f[3]);
                does.push_back(f[4]);
                bas.push_back(f[5]);
                ces.push_back(f[6]);
            end
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int fd;
        {rd_n, wr_n, mreq_n, iorq_n} = 4'hF;
        a = '0;
        d_in = '0;
        keys = '1;
        kb_wr_data = '0;
        kb_wr_en = 1'b0;
        cassette_in = 1'b0;
        printer_in = 1'b0;
        check = 1'b0;
        test_num = 0;
        cur_op = 0;
        {exp_dout, exp_doe, exp_ba, exp_ce} = '0;
        fd = $fopen("tb/sys_bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/sys_bus_testdata.txt");
            $display("Test failed");
            $finish;
        end else begin
            load_testdata(fd);
            $fclose(fd);
            limit = ops.size() * 10 + reset_cycles;
            repeat (reset_cycles) @(posedge clk);
            reset <= 1'b0;
            foreach (ops[i])
                run_line(i);
            repeat (3) @(posedge clk);
            $display("Done: %0d tests, %0d failing, %0d assertion failures", tests,
                     errors, DUT.u_assertions.fail_count);
            if (errors == 0 && DUT.u_assertions.fail_count == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
            $finish;
        end
    end

endmodule

// File: sys_bus_top.f
+incdir+hw
hw/z80_bus_pkg.sv
hw/mem_map_pkg.sv
hw/bus_sync.sv
hw/mem_decode.sv
hw/io_regs.sv
hw/keyboard.sv
hw/sys_bus_top.sv
tb/sys_bus_assertions.sv
tb/bus_checker.sv
tb/tb_top.sv

// File: Makefile
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
		-f sys_bus_top.f -Mdir obj_dir -o Vtb_top

run: build
	./obj_dir/Vtb_top +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing --top-module sys_bus_top -f sys_bus_top.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: tb/sys_bus_testdata.txt
# op: 0 mem rd, 1 mem wr, 2 io rd, 3 io wr, 4 key row, 5 push, 6 inputs, 7 pins
# op addr data exp_d_out exp_d_oe exp_ba ram_ce_n.cart_ce_n.ram_we_n (as 0xRCW)
2 00F0 00 C0 1 00 111
2 00F1 00 21 1 00 111
2 00F2 00 22 1 00 111
2 00F3 00 13 1 00 111
0 4000 00 00 0 01 011
1 8000 5A 00 0 02 010
0 C000 00 00 0 13 101
0 0000 00 00 0 00 111
0 3800 00 00 0 00 011
1 3FFF 11 00 0 00 010
3 00F1 94 00 0 00 111
0 4000 00 00 0 14 111
3 00F2 BF 00 0 00 111
0 8123 00 00 0 1F 011
1 8123 77 00 0 1F 111
3 00F3 50 00 0 00 111
0 FC00 00 00 0 00 011
1 D000 66 00 0 10 101
3 00F0 03 00 0 00 111
0 0100 00 00 0 03 111
2 00F2 00 BF 1 00 111
3 00FB 01 00 0 00 111
2 00F0 00 00 0 00 111
2 00FB 00 01 1 00 111
3 00FC 01 00 0 00 111
3 00FE 01 00 0 00 111
7 0000 00 03 0 00 111
3 00FC 00 00 0 00 111
7 0000 00 02 0 00 111
6 0000 00 00 0 00 111
2 00FC 00 01 1 00 111
2 00FE 00 00 1 00 111
6 0000 03 00 0 00 111
2 00FC 00 00 1 00 111
2 00FE 00 01 1 00 111
2 00FD 00 00 1 00 111
3 00FB 00 00 0 00 111
2 00F0 00 03 1 00 111
4 0000 FE 00 0 00 111
4 0001 FD 00 0 00 111
4 0002 7F 00 0 00 111
4 0003 EF 00 0 00 111
2 FFFF 00 FF 1 00 111
2 FEFF 00 FE 1 00 111
2 FCFF 00 FC 1 00 111
2 F3FF 00 6F 1 00 111
2 00FF 00 6C 1 00 111
2 00FA 00 00 1 00 111
5 0003 11 00 0 00 111
2 00FA 00 11 1 00 111
2 00FA 00 12 1 00 111
2 00FA 00 13 1 00 111
2 00FA 00 00 1 00 111
5 0002 30 00 0 00 111
3 00FA 00 00 0 00 111
2 00FA 00 00 1 00 111
5 0011 40 00 0 00 111
2 00FA 00 40 1 00 111
2 00FA 00 41 1 00 111
